//--- hw/zynq_addr_pkg.sv
package zynq_addr_pkg;

   //////////////////////////////
   // address map widths
   //////////////////////////////

   // the GP1 port drops the top two bits of the PS physical address
   localparam int host_addr_width = 30;

   // core and PS physical addresses
   localparam int bp_addr_width = 32;

   // each host window spans 256 MB
   localparam int host_offset_width = 28;

   // core cached DRAM starts here, PS DRAM is reached by removing it
   localparam logic [bp_addr_width-1:0] dram_base_flip = 32'h8000_0000;

   //////////////////////////////
   // memory profiler regions
   //////////////////////////////

   // bits 29..23 of a core address pick one of 128 regions of 8 MB
   localparam int region_msb = 29;
   localparam int region_width = 7;

   //////////////////////////////
   // host address views
   //////////////////////////////

   // raw word as it arrives from GP1, or split into window and offset
   typedef union packed {
      logic [host_addr_width-1:0] raw;
      struct packed {
         logic                         window;
         logic                         spare;
         logic [host_offset_width-1:0] offset;
      } f;
   } host_addr_u;

endpackage

//--- hw/zynq_csr_pkg.sv
package zynq_csr_pkg;

   // word address and data width of the host register bank
   localparam int csr_addr_width = 3;
   localparam int csr_data_width = 32;

   //////////////////////////////
   // register map
   //////////////////////////////

   // bit 0 is the core reset level, low true
   localparam int csr_reset_idx = 0;

   // PS physical base of the DRAM carved out for the core
   localparam int csr_dram_base_idx = 1;

   // first of the read-only profiler words, higher indices read zero
   localparam int csr_prof_idx = 2;

   // profiler bitmap and the number of words it spans
   localparam int prof_width = 128;
   localparam int prof_words = 4;

endpackage

//--- hw/dram_req_if.sv
// one translated DRAM request between the two DRAM stages
interface dram_req_if;

   // single-cycle strobe, the rest is only meaningful while it is high
   logic                                   v;
   logic                                   we;
   // address as the core issued it
   logic [zynq_addr_pkg::bp_addr_width-1:0] bp_addr;
   // same request in PS DRAM space
   logic [zynq_addr_pkg::bp_addr_width-1:0] ps_addr;

   modport producer (
      output v, we, bp_addr, ps_addr
   );

   modport consumer (
      input v, we, bp_addr, ps_addr
   );

endinterface

//--- hw/host_addr_xlate.sv
module host_addr_xlate
  (input  logic                                    aclk
   , input  logic                                  rst_i
   , input  logic                                  host_v_i
   , input  zynq_addr_pkg::host_addr_u             host_addr_i
   , output logic                                  host_v_o
   , output logic [zynq_addr_pkg::bp_addr_width-1:0] host_addr_o
   );

   localparam int pad_width =
      zynq_addr_pkg::bp_addr_width - 1 - zynq_addr_pkg::host_offset_width;

   logic [zynq_addr_pkg::bp_addr_width-1:0] core_addr;

   // upper window (GP1 0x2000_0000) -> core local space at 0
   // lower window (GP1 0x0000_0000) -> core cached DRAM at 0x8000_0000
   assign core_addr = {~host_addr_i.f.window
                       , {pad_width{1'b0}}
                       , host_addr_i.f.offset};

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         host_v_o <= 1'b0;
      end else begin
         host_v_o <= host_v_i;
      end
   end

   // address only moves with a request
   always_ff @(posedge aclk) begin
      if (host_v_i) begin
         host_addr_o <= core_addr;
      end
   end

endmodule

//--- hw/dram_addr_xlate.sv
module dram_addr_xlate
  (input  logic                                    aclk
   , input  logic                                  rst_i
   , input  logic                                  dram_v_i
   , input  logic                                  dram_we_i
   , input  logic [zynq_addr_pkg::bp_addr_width-1:0] dram_addr_i
   , input  logic [zynq_addr_pkg::bp_addr_width-1:0] dram_base_i
   , dram_req_if.producer                          req
   );

   logic [zynq_addr_pkg::bp_addr_width-1:0] ps_addr;

   //////////////////////////////
   // core DRAM -> PS DRAM
   //////////////////////////////

   // drop the core DRAM base bit, then offset into the buffer the PS
   // allocated for the core; the sum wraps at 4 GB
   assign ps_addr = (dram_addr_i ^ zynq_addr_pkg::dram_base_flip) + dram_base_i;

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         req.v <= 1'b0;
      end else begin
         req.v <= dram_v_i;
      end
   end

   // keep the core address too, the profiler indexes by it
   always_ff @(posedge aclk) begin
      if (dram_v_i) begin
         req.we      <= dram_we_i;
         req.bp_addr <= dram_addr_i;
         req.ps_addr <= ps_addr;
      end
   end

endmodule

//--- hw/mem_profiler.sv
module mem_profiler
  (input  logic                                  aclk
   , input  logic                                core_reset_i
   , dram_req_if.consumer                        req
   , output logic [zynq_csr_pkg::prof_width-1:0] prof_o
   );

   logic [zynq_addr_pkg::region_width-1:0] region;

   //////////////////////////////
   // region touched map
   //////////////////////////////

   // reads and writes both count as a touch
   assign region = req.bp_addr[zynq_addr_pkg::region_msb -: zynq_addr_pkg::region_width];

   // held clear for as long as the core sits in reset, so each run
   // starts with an empty map
   always_ff @(posedge aclk) begin
      if (core_reset_i) begin
         prof_o <= '0;
      end else if (req.v) begin
         prof_o[region] <= 1'b1;
      end
   end

endmodule

//--- hw/csr_regs.sv
module csr_regs
  (input  logic                                      aclk
   , input  logic                                    rst_i
   , input  logic                                    csr_we_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0] csr_addr_i
   , input  logic [zynq_csr_pkg::csr_data_width-1:0] csr_wdata_i
   , output logic [zynq_csr_pkg::csr_data_width-1:0] csr_rdata_o
   , input  logic [zynq_csr_pkg::prof_width-1:0]     prof_i
   , output logic                                    core_reset_o
   , output logic [zynq_csr_pkg::csr_data_width-1:0] dram_base_o
   );

   localparam int aw = zynq_csr_pkg::csr_addr_width;
   localparam int sel_width = $clog2(zynq_csr_pkg::prof_words);

   logic [zynq_csr_pkg::csr_data_width-1:0] reset_r;
   logic [zynq_csr_pkg::csr_data_width-1:0] dram_base_r;
   logic [zynq_csr_pkg::prof_words-1:0][zynq_csr_pkg::csr_data_width-1:0] prof_word;
   logic [aw-1:0]                           prof_off;
   logic [sel_width-1:0]                    prof_sel;

   //////////////////////////////
   // writable registers
   //////////////////////////////

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         reset_r     <= '0;
         dram_base_r <= '0;
      end else if (csr_we_i) begin
         // profiler indices and the spare ones take no write
         if (csr_addr_i == aw'(zynq_csr_pkg::csr_reset_idx)) begin
            reset_r <= csr_wdata_i;
         end
         if (csr_addr_i == aw'(zynq_csr_pkg::csr_dram_base_idx)) begin
            dram_base_r <= csr_wdata_i;
         end
      end
   end

   // register bit is low true, the core is also held during shell reset
   assign core_reset_o = rst_i | ~reset_r[0];
   assign dram_base_o  = dram_base_r;

   //////////////////////////////
   // readback
   //////////////////////////////

   assign prof_word = prof_i;

   // indices below the profiler wrap to large offsets and fall out of range
   assign prof_off = csr_addr_i - aw'(zynq_csr_pkg::csr_prof_idx);
   assign prof_sel = prof_off[sel_width-1:0];

   always_comb begin
      csr_rdata_o = '0;
      if (csr_addr_i == aw'(zynq_csr_pkg::csr_reset_idx)) begin
         csr_rdata_o = reset_r;
      end else if (csr_addr_i == aw'(zynq_csr_pkg::csr_dram_base_idx)) begin
         csr_rdata_o = dram_base_r;
      end else if (prof_off < aw'(zynq_csr_pkg::prof_words)) begin
         csr_rdata_o = prof_word[prof_sel];
      end
   end

endmodule

//--- hw/zynq_shell_top.sv
module zynq_shell_top
  (input  logic                                        aclk
   , input  logic                                      rst_i

   // host (GP1) requests into the core
   , input  logic                                      host_v_i
   , input  logic [zynq_addr_pkg::host_addr_width-1:0] host_addr_i
   , output logic                                      host_v_o
   , output logic [zynq_addr_pkg::bp_addr_width-1:0]   host_addr_o

   // core DRAM requests out to the PS
   , input  logic                                      dram_v_i
   , input  logic                                      dram_we_i
   , input  logic [zynq_addr_pkg::bp_addr_width-1:0]   dram_addr_i
   , output logic                                      dram_v_o
   , output logic                                      dram_we_o
   , output logic [zynq_addr_pkg::bp_addr_width-1:0]   dram_addr_o

   // control/status registers
   , input  logic                                      csr_we_i
   , input  logic [zynq_csr_pkg::csr_addr_width-1:0]   csr_addr_i
   , input  logic [zynq_csr_pkg::csr_data_width-1:0]   csr_wdata_i
   , output logic [zynq_csr_pkg::csr_data_width-1:0]   csr_rdata_o
   , output logic                                      core_reset_o
   );

   zynq_addr_pkg::host_addr_u                  host_addr_li;
   logic [zynq_csr_pkg::csr_data_width-1:0]    dram_base_lo;
   logic [zynq_csr_pkg::prof_width-1:0]        prof_lo;

   dram_req_if dram_req ();

   assign host_addr_li.raw = host_addr_i;

   //////////////////////////////
   // host window path
   //////////////////////////////

   host_addr_xlate u_host_addr_xlate
     (.aclk         (aclk)
      ,.rst_i       (rst_i)
      ,.host_v_i    (host_v_i)
      ,.host_addr_i (host_addr_li)
      ,.host_v_o    (host_v_o)
      ,.host_addr_o (host_addr_o)
      );

   //////////////////////////////
   // DRAM path
   //////////////////////////////

   dram_addr_xlate u_dram_addr_xlate
     (.aclk         (aclk)
      ,.rst_i       (rst_i)
      ,.dram_v_i    (dram_v_i)
      ,.dram_we_i   (dram_we_i)
      ,.dram_addr_i (dram_addr_i)
      ,.dram_base_i (dram_base_lo)
      ,.req         (dram_req.producer)
      );

   // PS side sees the translated request straight from the first stage
   assign dram_v_o    = dram_req.v;
   assign dram_we_o   = dram_req.we;
   assign dram_addr_o = dram_req.ps_addr;

   mem_profiler u_mem_profiler
     (.aclk          (aclk)
      ,.core_reset_i (core_reset_o)
      ,.req          (dram_req.consumer)
      ,.prof_o       (prof_lo)
      );

   //////////////////////////////
   // register bank
   //////////////////////////////

   csr_regs u_csr_regs
     (.aclk          (aclk)
      ,.rst_i        (rst_i)
      ,.csr_we_i     (csr_we_i)
      ,.csr_addr_i   (csr_addr_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.csr_rdata_o  (csr_rdata_o)
      ,.prof_i       (prof_lo)
      ,.core_reset_o (core_reset_o)
      ,.dram_base_o  (dram_base_lo)
      );

endmodule

//--- tests/shell_checker.sv
module shell_checker
  (input  logic        aclk
   , input  logic        rst_i

   // DUT outputs under watch
   , input  logic        dut_host_v_i
   , input  logic [31:0] dut_host_addr_i
   , input  logic        dut_dram_v_i
   , input  logic        dut_dram_we_i
   , input  logic [31:0] dut_dram_addr_i
   , input  logic [31:0] dut_csr_rdata_i
   , input  logic        dut_core_reset_i

   // expectations from the testbench reference model
   , input  logic        exp_host_v_i
   , input  logic [31:0] exp_host_addr_i
   , input  logic        exp_dram_v_i
   , input  logic        exp_dram_we_i
   , input  logic [31:0] exp_dram_addr_i
   , input  logic        csr_chk_i
   , input  logic [2:0]  csr_addr_i
   , input  logic [31:0] exp_csr_rdata_i
   , input  logic        reset_chk_i
   , input  logic        exp_core_reset_i

   , output int          err_count_o
   , output int          host_pend_o
   , output int          dram_pend_o
   );

   int          cyc;
   int          exp_cyc;
   logic [31:0] exp_addr;
   logic [32:0] exp_req;
   logic [31:0] host_q[$];
   int          host_cyc_q[$];
   logic [32:0] dram_q[$];
   int          dram_cyc_q[$];

   task automatic fail_value(string what, logic [31:0] got, logic [31:0] exp);
      $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
      err_count_o = err_count_o + 1;
   endtask

   task automatic fail_event(string what);
      $display("error at time %0t: %s", $time, what);
      err_count_o = err_count_o + 1;
   endtask

   always @(posedge aclk) begin
      cyc <= cyc + 1;
   end

   // outputs settle well before the falling edge
   always @(negedge aclk) begin
      //////////////////////////////
      // host path
      //////////////////////////////
      if (dut_host_v_i === 1'b1) begin
         if (host_q.size() == 0) begin
            fail_event("host_v_o pulsed with no host request outstanding");
         end else begin
            exp_addr = host_q.pop_front();
            exp_cyc  = host_cyc_q.pop_front();
            if (cyc != exp_cyc + 1) begin
               fail_event("host_v_o arrived on the wrong cycle");
            end
            if (dut_host_addr_i !== exp_addr) begin
               fail_value("host_addr_o", dut_host_addr_i, exp_addr);
            end
         end
      end else if (!rst_i && dut_host_v_i !== 1'b0) begin
         fail_event("host_v_o is unknown after reset");
      end else if (host_cyc_q.size() != 0 && host_cyc_q[0] + 1 <= cyc) begin
         fail_event("host_v_o did not pulse one cycle after its request");
         exp_addr = host_q.pop_front();
         exp_cyc  = host_cyc_q.pop_front();
      end
      if (exp_host_v_i) begin
         host_q.push_back(exp_host_addr_i);
         host_cyc_q.push_back(cyc);
      end
      host_pend_o = host_q.size();

      //////////////////////////////
      // DRAM path
      //////////////////////////////
      if (dut_dram_v_i === 1'b1) begin
         if (dram_q.size() == 0) begin
            fail_event("dram_v_o pulsed with no DRAM request outstanding");
         end else begin
            exp_req = dram_q.pop_front();
            exp_cyc = dram_cyc_q.pop_front();
            if (cyc != exp_cyc + 1) begin
               fail_event("dram_v_o arrived on the wrong cycle");
            end
            if (dut_dram_we_i !== exp_req[32]) begin
               fail_value("dram_we_o", {31'b0, dut_dram_we_i}, {31'b0, exp_req[32]});
            end
            if (dut_dram_addr_i !== exp_req[31:0]) begin
               fail_value("dram_addr_o", dut_dram_addr_i, exp_req[31:0]);
            end
         end
      end else if (!rst_i && dut_dram_v_i !== 1'b0) begin
         fail_event("dram_v_o is unknown after reset");
      end else if (dram_cyc_q.size() != 0 && dram_cyc_q[0] + 1 <= cyc) begin
         fail_event("dram_v_o did not pulse one cycle after its request");
         exp_req = dram_q.pop_front();
         exp_cyc = dram_cyc_q.pop_front();
      end
      if (exp_dram_v_i) begin
         dram_q.push_back({exp_dram_we_i, exp_dram_addr_i});
         dram_cyc_q.push_back(cyc);
      end
      dram_pend_o = dram_q.size();

      // register bank
      if (csr_chk_i && dut_csr_rdata_i !== exp_csr_rdata_i) begin
         fail_value($sformatf("csr_rdata_o at index %0d", csr_addr_i),
                    dut_csr_rdata_i, exp_csr_rdata_i);
      end
      if (reset_chk_i && dut_core_reset_i !== exp_core_reset_i) begin
         fail_value("core_reset_o", {31'b0, dut_core_reset_i}, {31'b0, exp_core_reset_i});
      end
   end

endmodule

//--- tests/tb_zynq_shell.sv
module tb_zynq_shell;

   localparam int drain_timeout = 50;

   logic                      aclk;
   logic                      rst_i;
   logic                      host_v_i;
   zynq_addr_pkg::host_addr_u host_addr_i;
   logic                      host_v_o;
   logic [31:0]               host_addr_o;
   logic                      dram_v_i;
   logic                      dram_we_i;
   logic [31:0]               dram_addr_i;
   logic                      dram_v_o;
   logic                      dram_we_o;
   logic [31:0]               dram_addr_o;
   logic                      csr_we_i;
   logic [2:0]                csr_addr_i;
   logic [31:0]               csr_wdata_i;
   logic [31:0]               csr_rdata_o;
   logic                      core_reset_o;

   // expectations handed to the checker
   logic        exp_host_v;
   logic [31:0] exp_host_addr;
   logic        exp_dram_v;
   logic        exp_dram_we;
   logic [31:0] exp_dram_addr;
   logic        csr_chk;
   logic [31:0] exp_csr_rdata;
   logic        reset_chk;
   logic        exp_core_reset;
   int          err_count;
   int          host_pend;
   int          dram_pend;

   // reference model state
   logic [31:0]  model_reset_reg;
   logic [31:0]  model_dram_base;
   logic [127:0] model_prof;
   int           tb_errors;
   int           tests_run;
   int           tests_failed;
   int           errors_before;
   int           seed_val;

   zynq_shell_top u_zynq_shell_top
     (.aclk          (aclk)
      ,.rst_i        (rst_i)
      ,.host_v_i     (host_v_i)
      ,.host_addr_i  (host_addr_i.raw)
      ,.host_v_o     (host_v_o)
      ,.host_addr_o  (host_addr_o)
      ,.dram_v_i     (dram_v_i)
      ,.dram_we_i    (dram_we_i)
      ,.dram_addr_i  (dram_addr_i)
      ,.dram_v_o     (dram_v_o)
      ,.dram_we_o    (dram_we_o)
      ,.dram_addr_o  (dram_addr_o)
      ,.csr_we_i     (csr_we_i)
      ,.csr_addr_i   (csr_addr_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.csr_rdata_o  (csr_rdata_o)
      ,.core_reset_o (core_reset_o)
      );

   shell_checker u_shell_checker
     (.aclk              (aclk)
      ,.rst_i            (rst_i)
      ,.dut_host_v_i     (host_v_o)
      ,.dut_host_addr_i  (host_addr_o)
      ,.dut_dram_v_i     (dram_v_o)
      ,.dut_dram_we_i    (dram_we_o)
      ,.dut_dram_addr_i  (dram_addr_o)
      ,.dut_csr_rdata_i  (csr_rdata_o)
      ,.dut_core_reset_i (core_reset_o)
      ,.exp_host_v_i     (exp_host_v)
      ,.exp_host_addr_i  (exp_host_addr)
      ,.exp_dram_v_i     (exp_dram_v)
      ,.exp_dram_we_i    (exp_dram_we)
      ,.exp_dram_addr_i  (exp_dram_addr)
      ,.csr_chk_i        (csr_chk)
      ,.csr_addr_i       (csr_addr_i)
      ,.exp_csr_rdata_i  (exp_csr_rdata)
      ,.reset_chk_i      (reset_chk)
      ,.exp_core_reset_i (exp_core_reset)
      ,.err_count_o      (err_count)
      ,.host_pend_o      (host_pend)
      ,.dram_pend_o      (dram_pend)
      );

   initial begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   //////////////////////////////
   // reference model
   //////////////////////////////

   // inverted window bit on top, then three zeros and the window offset
   function automatic logic [31:0] host_ref(zynq_addr_pkg::host_addr_u a);
      return {~a.f.window, 3'b000, a.f.offset};
   endfunction

   function automatic logic [31:0] dram_ref(logic [31:0] addr, logic [31:0] base);
      return (addr ^ 32'h8000_0000) + base;
   endfunction

   // 8 MB regions below the 1 GB line
   function automatic logic [6:0] region_ref(logic [31:0] addr);
      return addr[29:23];
   endfunction

   //////////////////////////////
   // stimulus tasks
   //////////////////////////////

   task automatic next_cycle();
      @(posedge aclk);
      #1;
   endtask

   task automatic quiet();
      host_v_i   = 1'b0;
      dram_v_i   = 1'b0;
      exp_host_v = 1'b0;
      exp_dram_v = 1'b0;
   endtask

   task automatic csr_write(logic [2:0] addr, logic [31:0] data);
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      if (addr == 3'd0) begin
         model_reset_reg = data;
         // core held in reset empties the map
         if (!data[0]) begin
            model_prof = '0;
         end
      end
      if (addr == 3'd1) begin
         model_dram_base = data;
      end
      next_cycle();
      csr_we_i = 1'b0;
   endtask

   task automatic csr_read_check(logic [2:0] addr, logic [31:0] exp);
      csr_addr_i    = addr;
      csr_chk       = 1'b1;
      exp_csr_rdata = exp;
      next_cycle();
      csr_chk = 1'b0;
   endtask

   task automatic check_core_reset(logic exp);
      reset_chk      = 1'b1;
      exp_core_reset = exp;
      next_cycle();
      reset_chk = 1'b0;
   endtask

   task automatic send_host(logic window);
      host_addr_i.raw      = 30'($urandom);
      host_addr_i.f.window = window;
      host_v_i             = 1'b1;
      exp_host_v           = 1'b1;
      exp_host_addr        = host_ref(host_addr_i);
      next_cycle();
   endtask

   task automatic send_dram(logic we, logic [31:0] addr);
      dram_v_i      = 1'b1;
      dram_we_i     = we;
      dram_addr_i   = addr;
      exp_dram_v    = 1'b1;
      exp_dram_we   = we;
      exp_dram_addr = dram_ref(addr, model_dram_base);
      if (model_reset_reg[0]) begin
         model_prof[region_ref(addr)] = 1'b1;
      end
      next_cycle();
   endtask

   task automatic wait_for_drain();
      int waited;
      waited = 0;
      while ((host_pend != 0 || dram_pend != 0) && waited < drain_timeout) begin
         next_cycle();
         waited++;
      end
      if (host_pend != 0) begin
         $display("timeout: a host request never produced its host_v_o strobe");
         tb_errors++;
      end
      if (dram_pend != 0) begin
         $display("timeout: a DRAM request never produced its dram_v_o strobe");
         tb_errors++;
      end
   endtask

   task automatic end_test(string name);
      int errs;
      errs = err_count + tb_errors - errors_before;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %0d, %s: %0d errors", tests_run, name, errs);
      errors_before = err_count + tb_errors;
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      int k;
      int total;
      seed_val        = $urandom(23088);
      rst_i           = 1'b1;
      host_addr_i.raw = '0;
      dram_we_i       = 1'b0;
      dram_addr_i     = '0;
      csr_we_i        = 1'b0;
      csr_addr_i      = '0;
      csr_wdata_i     = '0;
      csr_chk         = 1'b0;
      exp_csr_rdata   = '0;
      reset_chk       = 1'b0;
      exp_core_reset  = 1'b0;
      exp_host_addr   = '0;
      exp_dram_we     = 1'b0;
      exp_dram_addr   = '0;
      model_reset_reg = '0;
      model_dram_base = '0;
      model_prof      = '0;
      quiet();
      repeat (16) @(posedge aclk);
      #1;
      rst_i = 1'b0;

      // idle cycles, the checker flags any stray strobe
      repeat (4) next_cycle();
      check_core_reset(1'b1);
      for (k = 0; k < 8; k++) begin
         csr_read_check(3'(k), 32'h0);
      end
      end_test("reset defaults");

      // both windows, mostly back to back with a few gaps
      for (k = 0; k < 20; k++) begin
         if ($urandom % 5 == 0) begin
            quiet();
            next_cycle();
         end
         send_host(k % 2 == 0);
      end
      quiet();
      wait_for_drain();
      end_test("host translation");

      csr_write(3'd1, $urandom);
      for (k = 0; k < 24; k++) begin
         send_dram(1'($urandom), $urandom | 32'h8000_0000);
      end
      quiet();
      wait_for_drain();
      csr_read_check(3'd1, model_dram_base);
      end_test("DRAM translation");

      csr_write(3'd0, 32'h1);
      check_core_reset(1'b0);
      for (k = 0; k < 12; k++) begin
         send_dram(1'($urandom), {2'b10, 7'(k * 11), 23'($urandom)});
      end
      send_dram(1'b1, {2'b10, 7'd127, 23'($urandom)});
      send_dram(1'b0, {2'b10, 7'd0, 23'($urandom)});
      quiet();
      wait_for_drain();
      for (k = 0; k < 4; k++) begin
         csr_read_check(3'(2 + k), model_prof[32*k +: 32]);
      end
      end_test("profiler map");

      // the map clears on the edge after core reset rises
      csr_write(3'd0, 32'h0);
      check_core_reset(1'b1);
      for (k = 0; k < 4; k++) begin
         csr_read_check(3'(2 + k), model_prof[32*k +: 32]);
      end
      end_test("profiler clear on core reset");

      csr_write(3'd0, $urandom);
      csr_read_check(3'd0, model_reset_reg);
      csr_write(3'd1, $urandom);
      csr_read_check(3'd1, model_dram_base);
      for (k = 2; k < 8; k++) begin
         csr_write(3'(k), $urandom);
      end
      csr_read_check(3'd0, model_reset_reg);
      csr_read_check(3'd1, model_dram_base);
      for (k = 0; k < 4; k++) begin
         csr_read_check(3'(2 + k), model_prof[32*k +: 32]);
      end
      csr_read_check(3'd6, 32'h0);
      csr_read_check(3'd7, 32'h0);
      check_core_reset(~model_reset_reg[0]);
      end_test("CSR readback");

      total = err_count + tb_errors;
      $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
      if (total == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- vlog.f
hw/zynq_addr_pkg.sv
hw/zynq_csr_pkg.sv
hw/dram_req_if.sv
hw/host_addr_xlate.sv
hw/dram_addr_xlate.sv
hw/mem_profiler.sv
hw/csr_regs.sv
hw/zynq_shell_top.sv
tests/shell_checker.sv
tests/tb_zynq_shell.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_zynq_shell -o tb_zynq_shell

out=$(./obj_dir/tb_zynq_shell)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "^PASS: all tests$"
